// ==== logic/listen_engine.sv ====
/*
 * Listen engine model, grants forwarded listens up to the listen limit
 */
`timescale 1ns/1ns
`default_nettype none

`include "tcp_settings.svh"

module listen_engine (
  input  wire                      aclk,
  input  wire                      aresetn,
  input  wire                      req_valid,
  output logic                     req_ready,
  input  wire  tcp_pkg::tcp_port_t req_port,
  output logic                     rsp_valid,
  input  wire                      rsp_ready,
  output logic                     rsp_success
);

  import tcp_pkg::*;

  localparam int CNT_BITS = $clog2(`TCP_MAX_LISTEN + 1);
  localparam logic [CNT_BITS-1:0] MAX_LISTEN = `TCP_MAX_LISTEN;

  listen_eng_state_t state_q, state_d;

  logic [CNT_BITS-1:0] count_q;
  tcp_port_t           port_q;
  logic                grant_q;
  logic                grant;
  logic                rsp_take;

  assign req_ready = (state_q == ENG_IDLE);
  assign rsp_valid = (state_q == ENG_RSP);
  assign rsp_success = grant_q;
  assign rsp_take = rsp_valid && rsp_ready;

  // Room left below the listen limit
  assign grant = (count_q < MAX_LISTEN);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ENG_IDLE:   if (req_valid) state_d = ENG_DECIDE;
      ENG_DECIDE: state_d = ENG_RSP;
      ENG_RSP:    if (rsp_ready) state_d = ENG_IDLE;
      default:    state_d = ENG_IDLE;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_q <= ENG_IDLE;
      count_q <= '0;
    end else begin
      state_q <= state_d;
      // Count only once the grant is taken
      if (rsp_take && grant_q) count_q <= count_q + 1'b1;
    end
  end

  // Port and decision of the listen in flight
  always_ff @(posedge aclk) begin
    if (req_valid && req_ready) port_q <= req_port;
    if (state_q == ENG_DECIDE) grant_q <= grant;
  end

endmodule

`default_nettype wire

// ==== logic/port_ram_tp.sv ====
/*
 * Two-port RAM, byte writes and read on port A, read-only port B,
 * registered reads on both ports
 */
`timescale 1ns/1ns
`default_nettype none

module port_ram_tp #(
  parameter int ADDR_BITS = 4,
  parameter int DATA_BITS = 16
) (
  input  wire                      aclk,
  input  wire  [DATA_BITS/8-1:0]   a_we,
  input  wire  [ADDR_BITS-1:0]     a_addr,
  input  wire  [DATA_BITS-1:0]     a_data_in,
  output logic [DATA_BITS-1:0]     a_data_out,
  input  wire  [ADDR_BITS-1:0]     b_addr,
  output logic [DATA_BITS-1:0]     b_data_out
);

  localparam int DEPTH = 2 ** ADDR_BITS;

  logic [DATA_BITS-1:0] mem [DEPTH];

  // All entries start cleared
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  // Port A, per-byte write, read returns old word
  always_ff @(posedge aclk) begin
    for (int j = 0; j < DATA_BITS / 8; j++) begin
      if (a_we[j]) begin
        mem[a_addr][j*8 +: 8] <= a_data_in[j*8 +: 8];
      end
    end
    a_data_out <= mem[a_addr];
  end

  // Port B, read only
  always_ff @(posedge aclk) begin
    b_data_out <= mem[b_addr];
  end

endmodule

`default_nettype wire

// ==== logic/tcp_listen_top.sv ====
/*
 * Listen path top, port table joined to the listen engine
 */
`timescale 1ns/1ns
`default_nettype none

module tcp_listen_top (
  input  wire                        aclk,
  input  wire                        aresetn,
  input  wire                        s_listen_req_valid,
  output logic                       s_listen_req_ready,
  input  wire  tcp_pkg::listen_req_t s_listen_req_data,
  output logic                       m_listen_rsp_valid,
  input  wire                        m_listen_rsp_ready,
  output tcp_pkg::listen_rsp_t       m_listen_rsp_data,
  input  wire  tcp_pkg::tcp_port_t   lookup_port,
  output tcp_pkg::rsid_t             rsid_out,
  output logic                       port_open
);

  import tcp_pkg::*;

  // Table to engine channels
  logic      eng_req_valid;
  logic      eng_req_ready;
  tcp_port_t eng_req_port;
  logic      eng_rsp_valid;
  logic      eng_rsp_ready;
  logic      eng_rsp_success;

  tcp_port_table tcp_port_table_inst (
    .aclk(aclk),
    .aresetn(aresetn),
    .s_listen_req_valid(s_listen_req_valid),
    .s_listen_req_ready(s_listen_req_ready),
    .s_listen_req_data(s_listen_req_data),
    .m_listen_rsp_valid(m_listen_rsp_valid),
    .m_listen_rsp_ready(m_listen_rsp_ready),
    .m_listen_rsp_data(m_listen_rsp_data),
    .eng_req_valid(eng_req_valid),
    .eng_req_ready(eng_req_ready),
    .eng_req_port(eng_req_port),
    .eng_rsp_valid(eng_rsp_valid),
    .eng_rsp_ready(eng_rsp_ready),
    .eng_rsp_success(eng_rsp_success),
    .lookup_port(lookup_port),
    .rsid_out(rsid_out),
    .port_open(port_open)
  );

  listen_engine listen_engine_inst (
    .aclk(aclk),
    .aresetn(aresetn),
    .req_valid(eng_req_valid),
    .req_ready(eng_req_ready),
    .req_port(eng_req_port),
    .rsp_valid(eng_rsp_valid),
    .rsp_ready(eng_rsp_ready),
    .rsp_success(eng_rsp_success)
  );

endmodule

`default_nettype wire

// ==== logic/tcp_pkg.sv ====
/*
 * Types for the listen path: port and session ids,
 * listen request and response structs, FSM state enums
 */
`default_nettype none

`include "tcp_settings.svh"

package tcp_pkg;

  // Port number and receive session id
  typedef logic [`TCP_IP_PORT_BITS-1:0] tcp_port_t;
  typedef logic [`TCP_RSESSION_BITS-1:0] rsid_t;

  // Host listen request, port to open and owning session
  typedef struct packed {
    tcp_port_t ip_port;
    rsid_t     rsid;
  } listen_req_t;

  // Listen answer, rsid echoed from the request
  typedef struct packed {
    logic  open_port_success;
    rsid_t rsid;
  } listen_rsp_t;

  // Port table FSM
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LUP,
    ST_WAIT,
    ST_CHECK,
    ST_RSP_COL,
    ST_SEND,
    ST_RSP_WAIT
  } port_tbl_state_t;

  // Listen engine FSM
  typedef enum logic [1:0] {
    ENG_IDLE,
    ENG_DECIDE,
    ENG_RSP
  } listen_eng_state_t;

endpackage

`default_nettype wire

// ==== logic/tcp_port_table.sv ====
/*
 * Listen port table FSM with collision check against the RAM,
 * forwarding to the listen engine and a lookup port on RAM port B
 */
`timescale 1ns/1ns
`default_nettype none

`include "tcp_settings.svh"

module tcp_port_table (
  input  wire                        aclk,
  input  wire                        aresetn,
  // Host listen requests
  input  wire                        s_listen_req_valid,
  output logic                       s_listen_req_ready,
  input  wire  tcp_pkg::listen_req_t s_listen_req_data,
  // Listen responses to host
  output logic                       m_listen_rsp_valid,
  input  wire                        m_listen_rsp_ready,
  output tcp_pkg::listen_rsp_t       m_listen_rsp_data,
  // Engine request
  output logic                       eng_req_valid,
  input  wire                        eng_req_ready,
  output tcp_pkg::tcp_port_t         eng_req_port,
  // Engine response
  input  wire                        eng_rsp_valid,
  output logic                       eng_rsp_ready,
  input  wire                        eng_rsp_success,
  // Receive path lookup
  input  wire  tcp_pkg::tcp_port_t   lookup_port,
  output tcp_pkg::rsid_t             rsid_out,
  output logic                       port_open
);

  import tcp_pkg::*;

  localparam int ORDER = `TCP_PORT_ORDER;
  localparam int DATA_BITS = `TCP_PORT_TABLE_DATA_BITS;
  localparam int OPEN_BIT = `TCP_RSESSION_BITS;
  localparam tcp_port_t PORT_OFFS = `TCP_PORT_OFFS;

  port_tbl_state_t state_q, state_d;

  // Latched request
  tcp_port_t        port_q;
  logic [ORDER-1:0] idx_q;
  rsid_t            rsid_q;

  logic                   req_take;
  logic                   hit;
  logic [DATA_BITS/8-1:0] a_we;
  logic [DATA_BITS-1:0]   a_data_in;
  logic [DATA_BITS-1:0]   a_data_out;
  logic [ORDER-1:0]       b_addr;
  logic [DATA_BITS-1:0]   b_data_out;

  assign req_take = s_listen_req_valid && s_listen_req_ready;

  // Control state
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request payload, index is port minus window base
  always_ff @(posedge aclk) begin
    if (req_take) begin
      port_q <= s_listen_req_data.ip_port;
      idx_q  <= s_listen_req_data.ip_port[ORDER-1:0] - PORT_OFFS[ORDER-1:0];
      rsid_q <= s_listen_req_data.rsid;
    end
  end

  // Entry already open
  assign hit = a_data_out[OPEN_BIT];

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:     if (s_listen_req_valid) state_d = ST_LUP;
      // Two cycles cover the RAM read
      ST_LUP:      state_d = ST_WAIT;
      ST_WAIT:     state_d = ST_CHECK;
      ST_CHECK:    state_d = hit ? ST_RSP_COL : ST_SEND;
      ST_RSP_COL:  if (m_listen_rsp_ready) state_d = ST_IDLE;
      ST_SEND:     if (eng_req_ready) state_d = ST_RSP_WAIT;
      ST_RSP_WAIT: if (eng_rsp_valid && m_listen_rsp_ready) state_d = ST_IDLE;
      default:     state_d = ST_IDLE;
    endcase
  end

  // Handshakes and table write
  always_comb begin
    s_listen_req_ready = 1'b0;
    eng_req_valid = 1'b0;
    eng_rsp_ready = 1'b0;
    m_listen_rsp_valid = 1'b0;
    m_listen_rsp_data.open_port_success = 1'b0;
    m_listen_rsp_data.rsid = rsid_q;
    a_we = '0;
    case (state_q)
      ST_IDLE: s_listen_req_ready = 1'b1;
      // Collision answered here
      ST_RSP_COL: m_listen_rsp_valid = 1'b1;
      ST_SEND: eng_req_valid = 1'b1;
      // Engine answer passed straight through
      ST_RSP_WAIT: begin
        m_listen_rsp_valid = eng_rsp_valid;
        eng_rsp_ready = m_listen_rsp_ready;
        m_listen_rsp_data.open_port_success = eng_rsp_success;
        if (eng_rsp_valid && m_listen_rsp_ready && eng_rsp_success) begin
          a_we = '1;
        end
      end
      default: ;
    endcase
  end

  assign eng_req_port = port_q;

  // New entry, open flag over the rsid
  always_comb begin
    a_data_in = '0;
    a_data_in[OPEN_BIT] = 1'b1;
    a_data_in[OPEN_BIT-1:0] = rsid_q;
  end

  // Lookup index, same window offset
  assign b_addr = lookup_port[ORDER-1:0] - PORT_OFFS[ORDER-1:0];

  port_ram_tp #(
    .ADDR_BITS(ORDER),
    .DATA_BITS(DATA_BITS)
  ) port_ram_inst (
    .aclk(aclk),
    .a_we(a_we),
    .a_addr(idx_q),
    .a_data_in(a_data_in),
    .a_data_out(a_data_out),
    .b_addr(b_addr),
    .b_data_out(b_data_out)
  );

  assign rsid_out = b_data_out[OPEN_BIT-1:0];
  assign port_open = b_data_out[OPEN_BIT];

endmodule

`default_nettype wire

// ==== logic/tcp_settings.svh ====
/*
 * Shared sizes for the listen-port side of the TCP offload engine:
 * port window, session id width, table word and listen limit
 */
`ifndef TCP_SETTINGS_SVH
`define TCP_SETTINGS_SVH

// TCP port number width
`define TCP_IP_PORT_BITS 16
// Table index width, 16 entries
`define TCP_PORT_ORDER 4
// First port of the table window
`define TCP_PORT_OFFS 5000
// Receive session id width
`define TCP_RSESSION_BITS 10
// Table word, rsid low, open flag at bit TCP_RSESSION_BITS
`define TCP_PORT_TABLE_DATA_BITS 16
// Ports the listen engine will grant
`define TCP_MAX_LISTEN 3

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the listen path testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tcp_listen_sim

verilator --binary --timing -j 0 --top-module tcp_listen_tb -f vlog.f -o "$BIN"
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "tests failed" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

if [ "$run_status" -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

echo "Simulation finished cleanly"
exit 0

// ==== tests/tb_clock_gen.sv ====
/*
 * Free-running testbench clock, 100 ns period
 */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD = 100
) (
  output logic aclk
);

  // Low at start, toggles every half period
  initial aclk = 1'b0;
  always #(PERIOD / 2) aclk = ~aclk;

endmodule

`default_nettype wire

// ==== tests/tcp_listen_tb.sv ====
/*
 * Listen path testbench, table of listen and lookup rows applied in a loop,
 * random response back-pressure, compare tasks and per-wait timeouts
 */
`timescale 1ns/1ns
`default_nettype none

`include "tcp_settings.svh"

module tcp_listen_tb;

  import tcp_pkg::*;

  localparam int TIMEOUT = 50;

  typedef enum logic {
    LISTEN,
    LOOKUP
  } op_t;

  // One stimulus row
  typedef struct packed {
    op_t       op;
    tcp_port_t port;
    rsid_t     rsid;
    logic      exp_success;
    rsid_t     exp_rsid;
    logic      exp_open;
    logic      probe_en;
    tcp_port_t probe_port;
  } row_t;

  logic        aclk;
  logic        aresetn;
  logic        s_listen_req_valid;
  logic        s_listen_req_ready;
  listen_req_t s_listen_req_data;
  logic        m_listen_rsp_valid;
  logic        m_listen_rsp_ready;
  listen_rsp_t m_listen_rsp_data;
  tcp_port_t   lookup_port;
  rsid_t       rsid_out;
  logic        port_open;

  row_t  rows[$];
  string row_names[$];

  tb_clock_gen #(.PERIOD(100)) clock_gen_inst (.aclk(aclk));

  tcp_listen_top tcp_listen_top_inst (
    .aclk(aclk),
    .aresetn(aresetn),
    .s_listen_req_valid(s_listen_req_valid),
    .s_listen_req_ready(s_listen_req_ready),
    .s_listen_req_data(s_listen_req_data),
    .m_listen_rsp_valid(m_listen_rsp_valid),
    .m_listen_rsp_ready(m_listen_rsp_ready),
    .m_listen_rsp_data(m_listen_rsp_data),
    .lookup_port(lookup_port),
    .rsid_out(rsid_out),
    .port_open(port_open)
  );

  // Port k of the table window
  function automatic tcp_port_t win_port(input int k);
    return tcp_port_t'(`TCP_PORT_OFFS + k);
  endfunction

  function automatic void add_row(input string name, input op_t op, input tcp_port_t port,
                                  input rsid_t rsid, input logic exp_success,
                                  input rsid_t exp_rsid, input logic exp_open,
                                  input logic probe_en, input tcp_port_t probe_port);
    row_t r;
    r.op = op;
    r.port = port;
    r.rsid = rsid;
    r.exp_success = exp_success;
    r.exp_rsid = exp_rsid;
    r.exp_open = exp_open;
    r.probe_en = probe_en;
    r.probe_port = probe_port;
    rows.push_back(r);
    row_names.push_back(name);
  endfunction

  // Fail message, then stop
  task automatic stop_run();
    $display("tests failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
    stop_run();
  endtask

  task automatic check_rsp(input string name, input listen_rsp_t exp, input listen_rsp_t act);
    if (act !== exp) begin
      $display("[FAIL] %s expected success=%0b rsid=0x%03h actual success=%0b rsid=0x%03h",
               name, exp.open_port_success, exp.rsid, act.open_port_success, act.rsid);
      stop_run();
    end
  endtask

  task automatic check_lookup(input string name, input rsid_t exp_rsid, input logic exp_open,
                              input rsid_t act_rsid, input logic act_open);
    if (act_rsid !== exp_rsid || act_open !== exp_open) begin
      $display("[FAIL] %s expected open=%0b rsid=0x%03h actual open=%0b rsid=0x%03h",
               name, exp_open, exp_rsid, act_open, act_rsid);
      stop_run();
    end
  endtask

  // Registered lookup, result one cycle after the port is driven
  task automatic run_lookup(input string name, input row_t r);
    lookup_port = r.port;
    @(negedge aclk);
    check_lookup(name, r.exp_rsid, r.exp_open, rsid_out, port_open);
  endtask

  task automatic run_listen(input string name, input row_t r);
    int          waited;
    int          hold;
    listen_rsp_t exp;
    exp.open_port_success = r.exp_success;
    exp.rsid = r.exp_rsid;
    s_listen_req_data.ip_port = r.port;
    s_listen_req_data.rsid = r.rsid;
    s_listen_req_valid = 1'b1;
    // Ready seen here means transfer on the next rising edge
    waited = 0;
    while (!s_listen_req_ready) begin
      if (waited >= TIMEOUT) report_timeout("the listen request to be accepted");
      @(negedge aclk);
      waited++;
    end
    @(negedge aclk);
    s_listen_req_valid = 1'b0;
    // Closed port looked up while the listen is pending
    if (r.probe_en) begin
      lookup_port = r.probe_port;
      @(negedge aclk);
      check_lookup({name, "_probe"}, rsid_t'(0), 1'b0, rsid_out, port_open);
    end
    waited = 0;
    while (!m_listen_rsp_valid) begin
      if (waited >= TIMEOUT) report_timeout("the listen response");
      @(negedge aclk);
      waited++;
    end
    // Back-pressure, response must hold
    hold = int'($urandom % 8);
    repeat (hold) begin
      if (!m_listen_rsp_valid) begin
        $display("Listen response valid dropped while ready was low in %s", name);
        stop_run();
      end
      check_rsp(name, exp, m_listen_rsp_data);
      @(negedge aclk);
    end
    check_rsp(name, exp, m_listen_rsp_data);
    m_listen_rsp_ready = 1'b1;
    @(negedge aclk);
    m_listen_rsp_ready = 1'b0;
  endtask

  function automatic void build_table();
    // Empty table after reset
    add_row("reset_lookup_low", LOOKUP, win_port(0), '0, 1'b0, '0, 1'b0, 1'b0, '0);
    add_row("reset_lookup_mid", LOOKUP, win_port(7), '0, 1'b0, '0, 1'b0, 1'b0, '0);
    add_row("reset_lookup_high", LOOKUP, win_port(15), '0, 1'b0, '0, 1'b0, 1'b0, '0);
    // First grant and its entry
    add_row("listen_fresh_a", LISTEN, win_port(3), 10'h011, 1'b1, 10'h011, 1'b0,
            1'b1, win_port(9));
    add_row("lookup_open_a", LOOKUP, win_port(3), '0, 1'b0, 10'h011, 1'b1, 1'b0, '0);
    // Collision keeps the first owner
    add_row("listen_collide_a", LISTEN, win_port(3), 10'h022, 1'b0, 10'h022, 1'b0,
            1'b1, win_port(14));
    add_row("lookup_keeps_a", LOOKUP, win_port(3), '0, 1'b0, 10'h011, 1'b1, 1'b0, '0);
    add_row("listen_fresh_b", LISTEN, win_port(8), 10'h033, 1'b1, 10'h033, 1'b0, 1'b0, '0);
    add_row("listen_fresh_c", LISTEN, win_port(12), 10'h3ff, 1'b1, 10'h3ff, 1'b0,
            1'b1, win_port(0));
    // Listen limit of 3 reached
    add_row("listen_over_limit", LISTEN, win_port(1), 10'h044, 1'b0, 10'h044, 1'b0,
            1'b1, win_port(2));
    add_row("lookup_refused", LOOKUP, win_port(1), '0, 1'b0, '0, 1'b0, 1'b0, '0);
    add_row("lookup_open_b", LOOKUP, win_port(8), '0, 1'b0, 10'h033, 1'b1, 1'b0, '0);
    add_row("lookup_open_c", LOOKUP, win_port(12), '0, 1'b0, 10'h3ff, 1'b1, 1'b0, '0);
  endfunction

  initial begin
    void'($urandom(95220));
    aresetn = 1'b0;
    s_listen_req_valid = 1'b0;
    s_listen_req_data = '0;
    m_listen_rsp_ready = 1'b0;
    lookup_port = win_port(0);
    build_table();
    repeat (3) @(negedge aclk);
    aresetn = 1'b1;
    @(negedge aclk);
    foreach (rows[i]) begin
      if (rows[i].op == LISTEN) begin
        run_listen(row_names[i], rows[i]);
      end else begin
        run_lookup(row_names[i], rows[i]);
      end
    end
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+logic
logic/tcp_pkg.sv
logic/port_ram_tp.sv
logic/tcp_port_table.sv
logic/listen_engine.sv
logic/tcp_listen_top.sv
tests/tb_clock_gen.sv
tests/tcp_listen_tb.sv
